/* pipelinedCpu.f */
src/cpuPkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/hazardUnit.sv
src/pipelinedCpu.sv
sim/pipelinedCpu_checker.sv
sim/pipelinedCpuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the pipelined CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pipelinedCpuTb \
    -f pipelinedCpu.f -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

# Keep running after an assertion error so the testbench can report it
./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

/* sim/pipelinedCpuTb.sv */
`timescale 1ns/10ps

module pipelinedCpuTb;

    localparam int DataWords = 256;
    localparam int ClkPeriod = 100;
    localparam int ResetCycles = 16;
    localparam int IdleCycles = 20;
    localparam int MaxProgLen = 16;
    localparam int RandomTests = 40;
    localparam int NumTests = 4 + RandomTests;
    // Every program loops on its last word, so this bounds each test
    localparam int TestCycles = ResetCycles + 1 + MaxProgLen * 8 + IdleCycles;

    logic               clk;
    logic               reset;
    cpuPkg::instrWord_t instr;
    cpuPkg::data_t      instrAddr;
    cpuPkg::wbResult_t  wb;

    logic [15:0]   prog [256];
    int            progLen;
    cpuPkg::data_t modelRegs [8];
    cpuPkg::data_t modelMem [256];
    logic [10:0]   expected [$];   // {regIdx, data}
    int            passedTests;
    int            failedTests;

    pipelinedCpu #(.DataWords(DataWords)) dut (
        .clk(clk), .reset(reset), .instr(instr), .instrAddr(instrAddr), .wb(wb)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(NumTests * TestCycles * ClkPeriod);
        $display("Timeout: the run went past its cycle budget");
        $display("Test failed");
        $finish;
    end

    function automatic logic [15:0] encodeR(cpuPkg::funct_t f, logic [2:0] rd,
                                            logic [2:0] rs1, logic [2:0] rs2);
        return {cpuPkg::RType, f, rd, rs1, rs2};
    endfunction

    function automatic logic [15:0] encodeI(cpuPkg::opcode_t op, logic [2:0] rd,
                                            logic [2:0] rs1, logic [2:0] imm3);
        return {op, 3'd0, rd, rs1, imm3};
    endfunction

    function automatic logic [15:0] encodeJump(logic [5:0] off6);
        return {cpuPkg::Jump, 6'd0, off6};
    endfunction

    task automatic clearProgram();
        for (int i = 0; i < 256; i++) begin
            prog[i] = '0;
        end
        progLen = 0;
    endtask

    task automatic addWord(input logic [15:0] w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic writeModel(input logic [2:0] idx, input cpuPkg::data_t val);
        if (idx != 3'd0) begin
            modelRegs[idx] = val;
            expected.push_back({idx, val});
        end
    endtask

    // In-order ISA model, runs until the jump-to-self
    task automatic buildExpected();
        cpuPkg::data_t pc;
        cpuPkg::data_t a;
        cpuPkg::data_t b;
        cpuPkg::data_t immx;
        cpuPkg::data_t addr;
        logic [15:0]   w;
        pc = '0;
        expected.delete();
        for (int i = 0; i < 8; i++) begin
            modelRegs[i] = 8'(i);
        end
        for (int i = 0; i < 256; i++) begin
            modelMem[i] = '0;
        end
        for (int step = 0; step < 64; step++) begin
            w = prog[pc];
            a = modelRegs[w[5:3]];
            b = modelRegs[w[8:6]];                // Store data or BEQ operand
            immx = {{5{w[2]}}, w[2:0]};
            addr = (a + immx) & 8'(DataWords - 1);  // Wraps inside the memory
            if (w[15:12] == cpuPkg::Jump && w[5:0] == 6'd0) break;
            case (w[15:12])
                cpuPkg::RType: begin
                    case (w[11:9])
                        cpuPkg::Add: writeModel(w[8:6], a + modelRegs[w[2:0]]);
                        cpuPkg::Sub: writeModel(w[8:6], a - modelRegs[w[2:0]]);
                        cpuPkg::And: writeModel(w[8:6], a & modelRegs[w[2:0]]);
                        cpuPkg::Or:  writeModel(w[8:6], a | modelRegs[w[2:0]]);
                        cpuPkg::Xor: writeModel(w[8:6], a ^ modelRegs[w[2:0]]);
                        cpuPkg::Slt: begin
                            writeModel(w[8:6],
                                ($signed(a) < $signed(modelRegs[w[2:0]])) ? 8'd1 : 8'd0);
                        end
                        default: ;
                    endcase
                    pc = pc + 8'd1;
                end
                cpuPkg::Addi: begin
                    writeModel(w[8:6], a + immx);
                    pc = pc + 8'd1;
                end
                cpuPkg::Load: begin
                    writeModel(w[8:6], modelMem[addr]);
                    pc = pc + 8'd1;
                end
                cpuPkg::Store: begin
                    modelMem[addr] = b;
                    pc = pc + 8'd1;
                end
                cpuPkg::Beq: pc = (a == b) ? pc + immx : pc + 8'd1;
                cpuPkg::Jump: pc = pc + {{2{w[5]}}, w[5:0]};
                default: pc = pc + 8'd1;
            endcase
        end
    endtask

    task automatic runProgram(input string name);
        int          errs;
        int          idle;
        int          seen;
        logic [10:0] exp;
        errs = 0;
        idle = 0;
        seen = 0;
        buildExpected();
        @(negedge clk);
        reset = 1'b1;
        repeat (ResetCycles) begin
            instr = cpuPkg::instrWord_t'(prog[instrAddr]);
            @(negedge clk);
        end
        reset = 1'b0;
        instr = cpuPkg::instrWord_t'(prog[instrAddr]);
        while (expected.size() > 0 || idle < IdleCycles) begin
            @(negedge clk);
            if (wb.valid) begin
                idle = 0;
                seen++;
                assert (expected.size() > 0) else begin
                    $display("Extra writeback to r%0d in %s", wb.regIdx, name);
                    errs++;
                end
                if (expected.size() > 0) begin
                    exp = expected.pop_front();
                    assert (wb.regIdx == exp[10:8] && wb.data == exp[7:0]) else begin
                        $display("Fail %s: expected r%0d=%h, actual r%0d=%h",
                                 name, exp[10:8], exp[7:0], wb.regIdx, wb.data);
                        errs++;
                    end
                end
            end else begin
                idle++;
            end
            instr = cpuPkg::instrWord_t'(prog[instrAddr]);
        end
        if (errs == 0) passedTests++;
        else failedTests++;
        $display("%s: %0d writebacks, %0d errors", name, seen, errs);
    endtask

    task automatic makeRandomProgram();
        cpuPkg::funct_t functs [6];
        functs = '{cpuPkg::Add, cpuPkg::Sub, cpuPkg::And, cpuPkg::Or, cpuPkg::Xor, cpuPkg::Slt};
        clearProgram();
        for (int i = 0; i < MaxProgLen - 4; i++) begin
            case ($urandom_range(3, 0))
                0: addWord(encodeR(functs[$urandom_range(5, 0)], 3'($urandom_range(7, 0)),
                                   3'($urandom_range(7, 0)), 3'($urandom_range(7, 0))));
                1: addWord(encodeI(cpuPkg::Addi, 3'($urandom_range(7, 0)),
                                   3'($urandom_range(7, 0)), 3'($urandom_range(7, 0))));
                2: addWord(encodeI(cpuPkg::Load, 3'($urandom_range(7, 0)),
                                   3'($urandom_range(7, 0)), 3'($urandom_range(7, 0))));
                default: addWord(encodeI(cpuPkg::Store, 3'($urandom_range(7, 0)),
                                         3'($urandom_range(7, 0)), 3'($urandom_range(7, 0))));
            endcase
        end
        addWord(encodeJump(6'd0));
    endtask

    initial begin
        reset = 1'b1;
        instr = '0;
        passedTests = 0;
        failedTests = 0;
        void'($urandom(79));

        clearProgram();
        addWord(encodeR(cpuPkg::Add, 3'd1, 3'd2, 3'd3));
        addWord(encodeR(cpuPkg::Add, 3'd4, 3'd5, 3'd6));
        addWord(encodeR(cpuPkg::Add, 3'd7, 3'd7, 3'd0));
        addWord(encodeJump(6'd0));
        runProgram("reset values");

        clearProgram();   // Back-to-back chain, mem and wb forwarding
        addWord(encodeR(cpuPkg::Add, 3'd1, 3'd2, 3'd3));
        addWord(encodeR(cpuPkg::Sub, 3'd2, 3'd1, 3'd4));
        addWord(encodeR(cpuPkg::And, 3'd3, 3'd1, 3'd2));
        addWord(encodeR(cpuPkg::Or, 3'd4, 3'd3, 3'd1));
        addWord(encodeR(cpuPkg::Xor, 3'd5, 3'd4, 3'd3));
        addWord(encodeR(cpuPkg::Slt, 3'd6, 3'd2, 3'd5));
        addWord(encodeI(cpuPkg::Addi, 3'd7, 3'd0, 3'b101));
        addWord(encodeR(cpuPkg::Slt, 3'd1, 3'd7, 3'd2));
        addWord(encodeR(cpuPkg::Slt, 3'd2, 3'd2, 3'd7));
        addWord(encodeI(cpuPkg::Addi, 3'd3, 3'd7, 3'b100));
        addWord(encodeJump(6'd0));
        runProgram("alu forwarding");

        clearProgram();
        addWord(encodeI(cpuPkg::Addi, 3'd1, 3'd0, 3'd3));
        addWord(encodeI(cpuPkg::Store, 3'd5, 3'd1, 3'd1));
        addWord(encodeI(cpuPkg::Load, 3'd2, 3'd1, 3'd1));
        addWord(encodeR(cpuPkg::Add, 3'd3, 3'd2, 3'd2));    // Load-use stall
        addWord(encodeI(cpuPkg::Addi, 3'd4, 3'd0, 3'b111));
        addWord(encodeI(cpuPkg::Store, 3'd6, 3'd4, 3'd2));  // 0xff + 2 wraps to 1
        addWord(encodeI(cpuPkg::Load, 3'd5, 3'd0, 3'd1));
        addWord(encodeR(cpuPkg::Add, 3'd6, 3'd5, 3'd1));
        addWord(encodeI(cpuPkg::Load, 3'd1, 3'd4, 3'd2));
        addWord(encodeJump(6'd0));
        runProgram("store load");

        clearProgram();
        addWord(encodeI(cpuPkg::Beq, 3'd1, 3'd1, 3'd3));    // Taken
        addWord(encodeI(cpuPkg::Addi, 3'd2, 3'd0, 3'd1));
        addWord(encodeI(cpuPkg::Addi, 3'd3, 3'd0, 3'd1));
        addWord(encodeR(cpuPkg::Add, 3'd4, 3'd1, 3'd2));
        addWord(encodeI(cpuPkg::Beq, 3'd1, 3'd2, 3'd2));    // Not taken
        addWord(encodeI(cpuPkg::Addi, 3'd5, 3'd0, 3'd2));
        addWord(encodeJump(6'd3));
        addWord(encodeI(cpuPkg::Addi, 3'd6, 3'd0, 3'd1));
        addWord(encodeI(cpuPkg::Addi, 3'd7, 3'd0, 3'd1));
        addWord(encodeR(cpuPkg::Add, 3'd1, 3'd5, 3'd5));
        addWord(encodeJump(6'd0));
        runProgram("branch jump");

        for (int k = 0; k < RandomTests; k++) begin
            makeRandomProgram();
            runProgram($sformatf("random %0d", k));
        end

        $display("%0d tests passed, %0d tests with errors, %0d assertion errors",
                 passedTests, failedTests, dut.chk.failures);
        if (failedTests == 0 && dut.chk.failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sim/pipelinedCpu_checker.sv */
`timescale 1ns/10ps

module pipelinedCpuChecker (
    input logic              clk,
    input logic              reset,
    input cpuPkg::wbResult_t wb,
    input cpuPkg::data_t     instrAddr,
    input cpuPkg::redirect_t redirect,
    input logic              stall
);

    int failures = 0;   // Read by the testbench at the end of the run

    wbQuietInReset: assert property (@(posedge clk) reset |-> !wb.valid)
        else begin
            failures++;
            $error("Writeback valid while reset is active");
        end

    // r0 is never a writeback target
    wbNeverR0: assert property (@(posedge clk) disable iff (reset)
        wb.valid |-> wb.regIdx != '0)
        else begin
            failures++;
            $error("Writeback reported for register 0");
        end

    redirectLoadsPc: assert property (@(posedge clk) disable iff (reset)
        redirect.taken |=> instrAddr == $past(redirect.target))
        else begin
            failures++;
            $error("Fetch address does not follow the redirect target");
        end

    stallHoldsPc: assert property (@(posedge clk) disable iff (reset)
        (stall && !redirect.taken) |=> instrAddr == $past(instrAddr))
        else begin
            failures++;
            $error("Fetch address moved during a load-use stall");
        end

endmodule

bind pipelinedCpu pipelinedCpuChecker chk (
    .clk(clk), .reset(reset), .wb(wb), .instrAddr(instrAddr),
    .redirect(redirect), .stall(stall)
);

/* src/cpuPkg.sv */
package cpuPkg;

    localparam int DataWidth = 8;
    localparam int RegCount = 8;

    typedef logic [DataWidth-1:0] data_t;
    typedef logic [$clog2(RegCount)-1:0] regIdx_t;

    typedef enum logic [3:0] {
        RType = 4'd0,
        Load  = 4'd2,
        Store = 4'd3,
        Jump  = 4'd4,
        Addi  = 4'd8,
        Beq   = 4'd9
    } opcode_t;

    // R-type function codes
    typedef enum logic [2:0] {
        Add = 3'd0,
        Sub = 3'd1,
        And = 3'd4,
        Or  = 3'd5,
        Xor = 3'd6,
        Slt = 3'd7
    } funct_t;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt
    } aluOp_t;

    typedef struct packed {
        opcode_t opcode;
        funct_t  funct;
        regIdx_t rd;     // Bits 8:6
        regIdx_t rs1;    // Bits 5:3
        regIdx_t rs2;    // Bits 2:0
    } rFormat_t;

    typedef struct packed {
        opcode_t    opcode;
        funct_t     funct;
        regIdx_t    rd;      // Store data or BEQ operand for those opcodes
        regIdx_t    rs1;
        logic [2:0] imm3;
    } iFormat_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [5:0] spare;
        logic [5:0] off6;    // PC-relative jump offset
    } jFormat_t;

    // One instruction word, low bits read per opcode
    typedef union packed {
        rFormat_t r;
        iFormat_t i;
        jFormat_t j;
    } instrWord_t;

    typedef struct packed {
        logic   regWrite;
        logic   memWrite;
        logic   memToReg;
        logic   useImm;
        logic   isBranch;
        logic   isJump;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        data_t   pc;
        ctrl_t   ctrl;
        data_t   rs1Val;
        data_t   rs2Val;
        data_t   imm;      // Sign-extended imm3 or off6
        regIdx_t rd;
        regIdx_t rs1Idx;
        regIdx_t rs2Idx;
    } idEx_t;

    typedef struct packed {
        data_t   aluResult;
        data_t   storeData;
        regIdx_t rd;
        logic    regWrite;
        logic    memWrite;
        logic    memToReg;
    } exMem_t;

    typedef struct packed {
        logic    valid;
        regIdx_t regIdx;
        data_t   data;
    } wbResult_t;

    typedef struct packed {
        logic  taken;
        data_t target;
    } redirect_t;

    typedef enum logic [1:0] {
        None,
        FromMem,
        FromWb
    } forwardSel_t;

endpackage

/* src/decodeStage.sv */
`timescale 1ns/10ps

module decodeStage (
    input  logic               clk,
    input  logic               reset,
    input  cpuPkg::data_t      pcD,
    input  cpuPkg::instrWord_t instrD,
    input  cpuPkg::wbResult_t  wb,
    input  logic               flush,
    output cpuPkg::regIdx_t    rs1Idx,
    output cpuPkg::regIdx_t    rs2Idx,
    output logic               isLoad,
    output cpuPkg::idEx_t      idEx
);

    cpuPkg::data_t   regs [cpuPkg::RegCount];
    cpuPkg::ctrl_t   ctrl;
    cpuPkg::data_t   imm;
    cpuPkg::data_t   rs1Val;
    cpuPkg::data_t   rs2Val;

    // Decode/execute register fields
    cpuPkg::ctrl_t   ctrlQ;
    cpuPkg::data_t   pcQ;
    cpuPkg::data_t   rs1ValQ;
    cpuPkg::data_t   rs2ValQ;
    cpuPkg::data_t   immQ;
    cpuPkg::regIdx_t rdQ;
    cpuPkg::regIdx_t rs1IdxQ;
    cpuPkg::regIdx_t rs2IdxQ;

    always_comb begin
        ctrl = '0;           // Inactive, ALU op defaults to add
        imm = {{(cpuPkg::DataWidth - 3){instrD.i.imm3[2]}}, instrD.i.imm3};
        rs1Idx = instrD.r.rs1;
        rs2Idx = '0;         // No second source unless the opcode reads one
        case (instrD.r.opcode)
            cpuPkg::RType: begin
                rs2Idx = instrD.r.rs2;
                ctrl.regWrite = 1'b1;
                case (instrD.r.funct)
                    cpuPkg::Add: ctrl.aluOp = cpuPkg::AluAdd;
                    cpuPkg::Sub: ctrl.aluOp = cpuPkg::AluSub;
                    cpuPkg::And: ctrl.aluOp = cpuPkg::AluAnd;
                    cpuPkg::Or:  ctrl.aluOp = cpuPkg::AluOr;
                    cpuPkg::Xor: ctrl.aluOp = cpuPkg::AluXor;
                    cpuPkg::Slt: ctrl.aluOp = cpuPkg::AluSlt;
                    default:     ctrl.regWrite = 1'b0;   // Unassigned funct codes
                endcase
            end
            cpuPkg::Addi: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm = 1'b1;
            end
            cpuPkg::Load: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            cpuPkg::Store: begin
                ctrl.memWrite = 1'b1;
                ctrl.useImm = 1'b1;
                rs2Idx = instrD.i.rd;   // Store data register
            end
            cpuPkg::Beq: begin
                ctrl.isBranch = 1'b1;
                rs2Idx = instrD.i.rd;
            end
            cpuPkg::Jump: begin
                ctrl.isJump = 1'b1;
                rs1Idx = '0;            // Bits 5:3 are offset here
                imm = {{(cpuPkg::DataWidth - 6){instrD.j.off6[5]}}, instrD.j.off6};
            end
            default: begin
                rs1Idx = '0;
            end
        endcase
    end

    assign isLoad = ctrl.memToReg;

    // r0 reads zero, writeback data is visible in the same cycle
    assign rs1Val = (rs1Idx == '0) ? '0
                  : (wb.valid && wb.regIdx == rs1Idx) ? wb.data : regs[rs1Idx];
    assign rs2Val = (rs2Idx == '0) ? '0
                  : (wb.valid && wb.regIdx == rs2Idx) ? wb.data : regs[rs2Idx];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < cpuPkg::RegCount; i++) begin
                regs[i] <= cpuPkg::data_t'(i);   // Register i starts at i
            end
        end else if (wb.valid && wb.regIdx != '0) begin
            regs[wb.regIdx] <= wb.data;
        end
    end

    // Bubble on load-use or redirect
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrlQ <= '0;
        end else if (flush) begin
            ctrlQ <= '0;
        end else begin
            ctrlQ <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        pcQ <= pcD;
        rs1ValQ <= rs1Val;
        rs2ValQ <= rs2Val;
        immQ <= imm;
        rdQ <= instrD.r.rd;
        rs1IdxQ <= rs1Idx;
        rs2IdxQ <= rs2Idx;
    end

    assign idEx = '{pc: pcQ, ctrl: ctrlQ, rs1Val: rs1ValQ, rs2Val: rs2ValQ, imm: immQ,
                    rd: rdQ, rs1Idx: rs1IdxQ, rs2Idx: rs2IdxQ};

endmodule

/* src/executeStage.sv */
`timescale 1ns/10ps

module executeStage (
    input  logic                clk,
    input  logic                reset,
    input  cpuPkg::idEx_t       idEx,
    input  cpuPkg::forwardSel_t fwdA,
    input  cpuPkg::forwardSel_t fwdB,
    input  cpuPkg::data_t       memAluResult,
    input  cpuPkg::wbResult_t   wb,
    output cpuPkg::exMem_t      exMem,
    output cpuPkg::redirect_t   redirect,
    output cpuPkg::regIdx_t     rdE,
    output logic                loadE
);

    cpuPkg::data_t   srcA;
    cpuPkg::data_t   srcB;
    cpuPkg::data_t   aluB;
    cpuPkg::data_t   aluResult;
    logic            taken;

    // Execute/memory register fields
    logic            regWriteQ;
    logic            memWriteQ;
    logic            memToRegQ;
    cpuPkg::data_t   aluResultQ;
    cpuPkg::data_t   storeDataQ;
    cpuPkg::regIdx_t rdQ;

    function automatic cpuPkg::data_t pickOperand(
        input cpuPkg::forwardSel_t sel,
        input cpuPkg::data_t       regVal,
        input cpuPkg::data_t       memVal,
        input cpuPkg::data_t       wbVal
    );
        case (sel)
            cpuPkg::FromMem: return memVal;
            cpuPkg::FromWb:  return wbVal;
            default:         return regVal;
        endcase
    endfunction

    assign srcA = pickOperand(fwdA, idEx.rs1Val, memAluResult, wb.data);
    assign srcB = pickOperand(fwdB, idEx.rs2Val, memAluResult, wb.data);
    assign aluB = idEx.ctrl.useImm ? idEx.imm : srcB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            cpuPkg::AluAdd: aluResult = srcA + aluB;
            cpuPkg::AluSub: aluResult = srcA - aluB;
            cpuPkg::AluAnd: aluResult = srcA & aluB;
            cpuPkg::AluOr:  aluResult = srcA | aluB;
            cpuPkg::AluXor: aluResult = srcA ^ aluB;
            cpuPkg::AluSlt: begin
                aluResult = ($signed(srcA) < $signed(aluB)) ? cpuPkg::DataWidth'(1) : '0;
            end
            default:        aluResult = '0;
        endcase
    end

    // BEQ compares the two register operands, never the immediate
    assign taken = idEx.ctrl.isJump | (idEx.ctrl.isBranch & (srcA == srcB));
    assign redirect = '{taken: taken, target: idEx.pc + idEx.imm};

    assign rdE = idEx.rd;
    assign loadE = idEx.ctrl.memToReg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regWriteQ <= 1'b0;
            memWriteQ <= 1'b0;
            memToRegQ <= 1'b0;
        end else begin
            regWriteQ <= idEx.ctrl.regWrite;
            memWriteQ <= idEx.ctrl.memWrite;
            memToRegQ <= idEx.ctrl.memToReg;
        end
    end

    always_ff @(posedge clk) begin
        aluResultQ <= aluResult;   // Also the memory address
        storeDataQ <= srcB;
        rdQ <= idEx.rd;
    end

    assign exMem = '{aluResult: aluResultQ, storeData: storeDataQ, rd: rdQ,
                     regWrite: regWriteQ, memWrite: memWriteQ, memToReg: memToRegQ};

endmodule

/* src/fetchStage.sv */
`timescale 1ns/10ps

module fetchStage (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall,
    input  cpuPkg::redirect_t  redirect,
    input  cpuPkg::instrWord_t instr,
    output cpuPkg::data_t      instrAddr,
    output cpuPkg::data_t      pcD,
    output cpuPkg::instrWord_t instrD
);

    cpuPkg::data_t pc;

    assign instrAddr = pc;   // Instruction comes back in the same cycle

    // Redirect wins over a load-use hold
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect.taken) begin
            pc <= redirect.target;
        end else if (!stall) begin
            pc <= pc + cpuPkg::DataWidth'(1);
        end
    end

    // All-zero word is ADD r0, which never writes back
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instrD <= '0;
        end else if (redirect.taken) begin
            instrD <= '0;    // Drop the wrong-path fetch
        end else if (!stall) begin
            instrD <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcD <= pc;
        end
    end

endmodule

/* src/hazardUnit.sv */
`timescale 1ns/10ps

module hazardUnit (
    input  cpuPkg::regIdx_t     rs1Idx,
    input  cpuPkg::regIdx_t     rs2Idx,
    input  cpuPkg::regIdx_t     rdE,
    input  logic                loadE,
    input  cpuPkg::exMem_t      exMem,
    input  cpuPkg::wbResult_t   wb,
    input  cpuPkg::regIdx_t     srcE1,
    input  cpuPkg::regIdx_t     srcE2,
    input  cpuPkg::redirect_t   redirect,
    output logic                stall,
    output logic                flushD,
    output logic                flushE,
    output cpuPkg::forwardSel_t fwdA,
    output cpuPkg::forwardSel_t fwdB
);

    logic loadUse;

    // Memory stage is younger, so it wins over writeback
    function automatic cpuPkg::forwardSel_t selectForward(
        input cpuPkg::regIdx_t   src,
        input cpuPkg::exMem_t    m,
        input cpuPkg::wbResult_t w
    );
        if (src == '0) return cpuPkg::None;
        if (m.regWrite && m.rd == src) return cpuPkg::FromMem;
        if (w.valid && w.regIdx == src) return cpuPkg::FromWb;
        return cpuPkg::None;
    endfunction

    assign loadUse = loadE && (rdE != '0) && (rdE == rs1Idx || rdE == rs2Idx);

    assign stall = loadUse && !redirect.taken;
    assign flushD = redirect.taken;
    assign flushE = redirect.taken || loadUse;   // Bubble into execute

    assign fwdA = selectForward(srcE1, exMem, wb);
    assign fwdB = selectForward(srcE2, exMem, wb);

endmodule

/* src/memoryStage.sv */
`timescale 1ns/10ps

module memoryStage #(
    parameter int DataWords = 256
) (
    input  logic              clk,
    input  logic              reset,
    input  cpuPkg::exMem_t    exMem,
    output cpuPkg::data_t     memAluResult,
    output cpuPkg::wbResult_t wb
);

    localparam int AddrBits = $clog2(DataWords);

    cpuPkg::data_t   mem [DataWords];
    logic [AddrBits-1:0] addr;
    cpuPkg::data_t   result;

    logic            wbValid;
    cpuPkg::regIdx_t wbIdx;
    cpuPkg::data_t   wbData;

    assign memAluResult = exMem.aluResult;           // Forward source for execute
    assign addr = exMem.aluResult[AddrBits-1:0];     // Upper address bits wrap

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DataWords; i++) begin
                mem[i] <= '0;
            end
        end else if (exMem.memWrite) begin
            mem[addr] <= exMem.storeData;
        end
    end

    // Asynchronous read, load data settles within the memory cycle
    assign result = exMem.memToReg ? mem[addr] : exMem.aluResult;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= exMem.regWrite && (exMem.rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        wbIdx <= exMem.rd;
        wbData <= result;
    end

    assign wb = '{valid: wbValid, regIdx: wbIdx, data: wbData};

endmodule

/* src/pipelinedCpu.sv */
`timescale 1ns/10ps

module pipelinedCpu #(
    parameter int DataWords = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  cpuPkg::instrWord_t instr,
    output cpuPkg::data_t      instrAddr,
    output cpuPkg::wbResult_t  wb
);

    cpuPkg::data_t       pcD;
    cpuPkg::instrWord_t  instrD;
    cpuPkg::regIdx_t     rs1Idx;
    cpuPkg::regIdx_t     rs2Idx;
    cpuPkg::idEx_t       idEx;
    cpuPkg::exMem_t      exMem;
    cpuPkg::redirect_t   redirect;
    cpuPkg::regIdx_t     rdE;
    logic                loadE;
    cpuPkg::data_t       memAluResult;
    logic                stall;
    logic                flushE;
    cpuPkg::forwardSel_t fwdA;
    cpuPkg::forwardSel_t fwdB;

    fetchStage fetch (
        .clk(clk), .reset(reset), .stall(stall), .redirect(redirect), .instr(instr),
        .instrAddr(instrAddr), .pcD(pcD), .instrD(instrD)
    );

    // Decode flag stays local, hazards look at the load already in execute
    decodeStage decode (
        .clk(clk), .reset(reset), .pcD(pcD), .instrD(instrD), .wb(wb), .flush(flushE),
        .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .isLoad(), .idEx(idEx)
    );

    executeStage execute (
        .clk(clk), .reset(reset), .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
        .memAluResult(memAluResult), .wb(wb), .exMem(exMem), .redirect(redirect),
        .rdE(rdE), .loadE(loadE)
    );

    memoryStage #(.DataWords(DataWords)) memory (
        .clk(clk), .reset(reset), .exMem(exMem), .memAluResult(memAluResult), .wb(wb)
    );

    // Fetch clears its own register from redirect.taken
    hazardUnit hazard (
        .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rdE(rdE), .loadE(loadE), .exMem(exMem), .wb(wb),
        .srcE1(idEx.rs1Idx), .srcE2(idEx.rs2Idx), .redirect(redirect),
        .stall(stall), .flushD(), .flushE(flushE), .fwdA(fwdA), .fwdB(fwdB)
    );

endmodule
